// ==== verilog/rv_cfg.svh ====
//----------------------------------------------------------------------
// Core configuration for the multicycle RV32 subset
// RV_XLEN is fixed at 32; the decoder relies on the RV32 encoding
//----------------------------------------------------------------------
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Reset vector
`define RV_RESET_PC 32'h0000_0200

// Data path and register file geometry
`define RV_XLEN      32
`define RV_NREGS     32
`define RV_REG_IDX_W 5

// CSR field width and the two manager CSRs
`define RV_CSR_W         12
`define RV_CSR_MNGR2PROC 12'hFC0
`define RV_CSR_PROC2MNGR 12'h7C0

`endif

// ==== verilog/rv_pkg.sv ====
//----------------------------------------------------------------------
// Shared types for the multicycle core
// Widths follow rv_cfg.svh
//----------------------------------------------------------------------
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]      word_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`RV_CSR_W-1:0]     csr_t;

  // Instruction classes seen by control and ALU
  typedef enum logic [3:0] {
    CL_ALU_R,
    CL_ALU_I,
    CL_LUI,
    CL_BRANCH,
    CL_JAL,
    CL_JALR,
    CL_LOAD,
    CL_STORE,
    CL_CSRR,
    CL_CSRW,
    CL_NOP
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // One pass per instruction: IDLE, IREQ, IWAIT, EXEC, optional EWAIT
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IREQ,
    ST_IWAIT,
    ST_EXEC,
    ST_EWAIT
  } ctrl_state_e;

endpackage

// ==== verilog/rv_dec_if.sv ====
//----------------------------------------------------------------------
// Decoded instruction fields, decoder to control and ALU
// imm is already sign-extended, or the upper 20 bits for LUI
//----------------------------------------------------------------------
interface rv_dec_if;
  import rv_pkg::*;

  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  word_t       imm;
  inst_class_e inst_class;
  alu_op_e     alu_op;
  br_cond_e    br_cond;
  logic        csr_ok;

  modport decoder (
    output rs1, rs2, rd, imm, inst_class, alu_op, br_cond, csr_ok
  );

  modport ctrl (
    input rs1, rs2, rd, imm, inst_class, alu_op, br_cond, csr_ok
  );

  modport alu (
    input imm, inst_class, alu_op, br_cond
  );

endinterface

// ==== verilog/rv_decode.sv ====
//----------------------------------------------------------------------
// Combinational decoder for the tinyrv2 subset
// Unrecognized encodings, MUL and AUIPC included, decode as CL_NOP
//----------------------------------------------------------------------
`include "rv_cfg.svh"

module rv_decode (
  input  rv_pkg::word_t inst_i,
  rv_dec_if.decoder     dec
);
  import rv_pkg::*;

  logic [2:0]  funct3;
  csr_t        csr;
  inst_class_e cls;
  word_t       imm_i;
  word_t       imm_sh;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_u;
  word_t       imm_j;

  assign funct3 = inst_i[14:12];
  assign csr    = inst_i[31:20];

  // Immediate formats
  assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_sh = {27'b0, inst_i[24:20]};
  assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b  = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u  = {inst_i[31:12], 12'b0};
  assign imm_j  = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  //--------------------------------------------------------------------
  // Instruction class
  //--------------------------------------------------------------------
  always_comb begin
    cls = CL_NOP;
    casez (inst_i)
      // Register ops; SUB and SRA are the only funct7 variants
      32'b0000000_?????_?????_???_?????_0110011,
      32'b0100000_?????_?????_000_?????_0110011,
      32'b0100000_?????_?????_101_?????_0110011: cls = CL_ALU_R;
      // Immediate ops, non-shift funct3 then shifts
      32'b???????_?????_?????_?1?_?????_0010011,
      32'b???????_?????_?????_?00_?????_0010011,
      32'b0000000_?????_?????_?01_?????_0010011,
      32'b0100000_?????_?????_101_?????_0010011: cls = CL_ALU_I;
      32'b???????_?????_?????_???_?????_0110111: cls = CL_LUI;
      // Branches, funct3 010 and 011 are reserved
      32'b???????_?????_?????_?0?_?????_1100011,
      32'b???????_?????_?????_11?_?????_1100011: cls = CL_BRANCH;
      32'b???????_?????_?????_???_?????_1101111: cls = CL_JAL;
      32'b???????_?????_?????_000_?????_1100111: cls = CL_JALR;
      32'b???????_?????_?????_010_?????_0000011: cls = CL_LOAD;
      32'b???????_?????_?????_010_?????_0100011: cls = CL_STORE;
      // CSRR is csrrs rd, csr, x0 and CSRW is csrrw x0, csr, rs1
      32'b???????_?????_00000_010_?????_1110011: cls = CL_CSRR;
      32'b???????_?????_?????_001_00000_1110011: cls = CL_CSRW;
      default:                                   cls = CL_NOP;
    endcase
  end

  // Immediate for the class
  always_comb begin
    case (cls)
      CL_STORE:  dec.imm = imm_s;
      CL_BRANCH: dec.imm = imm_b;
      CL_LUI:    dec.imm = imm_u;
      CL_JAL:    dec.imm = imm_j;
      CL_ALU_I:  dec.imm = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
      default:   dec.imm = imm_i;
    endcase
  end

  // ALU op from funct3, bit 30 picks SUB (register form only) and SRA
  always_comb begin
    case (funct3)
      3'b000:  dec.alu_op = (cls == CL_ALU_R && inst_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  dec.alu_op = ALU_SLL;
      3'b010:  dec.alu_op = ALU_SLT;
      3'b011:  dec.alu_op = ALU_SLTU;
      3'b100:  dec.alu_op = ALU_XOR;
      3'b101:  dec.alu_op = inst_i[30] ? ALU_SRA : ALU_SRL;
      3'b110:  dec.alu_op = ALU_OR;
      default: dec.alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b001:  dec.br_cond = BR_NE;
      3'b100:  dec.br_cond = BR_LT;
      3'b101:  dec.br_cond = BR_GE;
      3'b110:  dec.br_cond = BR_LTU;
      3'b111:  dec.br_cond = BR_GEU;
      default: dec.br_cond = BR_EQ;
    endcase
  end

  assign dec.inst_class = cls;
  assign dec.rs1        = inst_i[19:15];
  assign dec.rs2        = inst_i[24:20];
  assign dec.rd         = inst_i[11:7];
  assign dec.csr_ok     = (cls == CL_CSRR && csr == `RV_CSR_MNGR2PROC) ||
                          (cls == CL_CSRW && csr == `RV_CSR_PROC2MNGR);

endmodule

// ==== verilog/rv_regfile.sv ====
//----------------------------------------------------------------------
// Integer register file, two combinational reads and one write port
// Writes to x0 are dropped; every entry clears on reset
//----------------------------------------------------------------------
`include "rv_cfg.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  input  rv_pkg::reg_idx_t wr_idx_i,
  input  logic             wr_en_i,
  input  rv_pkg::word_t    wr_data_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o
);
  import rv_pkg::*;

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != '0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  // x0 is cleared by reset and never written afterwards
  a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    (rs1_i != '0 || rs1_data_o == '0) && (rs2_i != '0 || rs2_data_o == '0));

endmodule

// ==== verilog/rv_alu.sv ====
//----------------------------------------------------------------------
// ALU, branch compare and effective-address add
// Loads, stores and JALR always add rs1 and imm
//----------------------------------------------------------------------
module rv_alu (
  rv_dec_if.alu         dec,
  input  rv_pkg::word_t rs1_data_i,
  input  rv_pkg::word_t rs2_data_i,
  output rv_pkg::word_t result_o,
  output logic          br_taken_o
);
  import rv_pkg::*;

  word_t   opb;
  alu_op_e op;
  logic    addr_form;

  assign addr_form = dec.inst_class inside {CL_LOAD, CL_STORE, CL_JALR};
  assign opb       = (addr_form || dec.inst_class == CL_ALU_I) ? dec.imm : rs2_data_i;
  assign op        = addr_form ? ALU_ADD : dec.alu_op;

  always_comb begin
    case (op)
      ALU_SUB:  result_o = rs1_data_i - opb;
      ALU_AND:  result_o = rs1_data_i & opb;
      ALU_OR:   result_o = rs1_data_i | opb;
      ALU_XOR:  result_o = rs1_data_i ^ opb;
      ALU_SLT:  result_o = word_t'($signed(rs1_data_i) < $signed(opb));
      ALU_SLTU: result_o = word_t'(rs1_data_i < opb);
      // Shift amount is the low 5 bits only
      ALU_SLL:  result_o = rs1_data_i << opb[4:0];
      ALU_SRL:  result_o = rs1_data_i >> opb[4:0];
      ALU_SRA:  result_o = $signed(rs1_data_i) >>> opb[4:0];
      default:  result_o = rs1_data_i + opb;
    endcase
  end

  // Branch condition on the register operands
  always_comb begin
    case (dec.br_cond)
      BR_NE:   br_taken_o = rs1_data_i != rs2_data_i;
      BR_LT:   br_taken_o = $signed(rs1_data_i) < $signed(rs2_data_i);
      BR_GE:   br_taken_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
      BR_LTU:  br_taken_o = rs1_data_i < rs2_data_i;
      BR_GEU:  br_taken_o = rs1_data_i >= rs2_data_i;
      default: br_taken_o = rs1_data_i == rs2_data_i;
    endcase
  end

endmodule

// ==== verilog/rv_ctrl.sv ====
//----------------------------------------------------------------------
// Multicycle control with PC, instruction register and handshakes
// One instruction in flight; requests hold val and data until accepted
//----------------------------------------------------------------------
`include "rv_cfg.svh"

module rv_ctrl (
  input  logic             clk,
  input  logic             reset,
  rv_dec_if.ctrl           dec,
  output rv_pkg::word_t    inst_o,
  input  rv_pkg::word_t    alu_result_i,
  input  logic             br_taken_i,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  output logic             rf_wr_en_o,
  output rv_pkg::reg_idx_t rf_wr_idx_o,
  output rv_pkg::word_t    rf_wr_data_o,
  input  rv_pkg::word_t    mngr2proc_msg_i,
  input  logic             mngr2proc_val_i,
  output logic             mngr2proc_rdy_o,
  output rv_pkg::word_t    proc2mngr_msg_o,
  output logic             proc2mngr_val_o,
  input  logic             proc2mngr_rdy_i,
  output logic             imem_req_val_o,
  input  logic             imem_req_rdy_i,
  output rv_pkg::word_t    imem_req_addr_o,
  input  logic             imem_resp_val_i,
  output logic             imem_resp_rdy_o,
  input  rv_pkg::word_t    imem_resp_data_i,
  output logic             dmem_req_val_o,
  input  logic             dmem_req_rdy_i,
  output logic             dmem_req_we_o,
  output rv_pkg::word_t    dmem_req_wdata_o,
  input  logic             dmem_resp_val_i,
  output logic             dmem_resp_rdy_o,
  input  rv_pkg::word_t    dmem_resp_data_i
);
  import rv_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  word_t       pc_q;
  word_t       pc_d;
  word_t       pc_plus4;
  word_t       ir_q;
  logic        pc_en;
  logic        in_exec;

  assign pc_plus4 = pc_q + 32'd4;
  assign in_exec  = state_q == ST_EXEC;

  //--------------------------------------------------------------------
  // Next state, next PC and writeback
  //--------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    pc_d         = pc_plus4;
    rf_wr_en_o   = 1'b0;
    rf_wr_data_o = alu_result_i;
    case (state_q)
      ST_IDLE:  state_d = ST_IREQ;
      ST_IREQ:  state_d = imem_req_rdy_i ? ST_IWAIT : ST_IREQ;
      ST_IWAIT: state_d = imem_resp_val_i ? ST_EXEC : ST_IWAIT;
      ST_EXEC: begin
        state_d = ST_IDLE;
        case (dec.inst_class)
          CL_ALU_R, CL_ALU_I: rf_wr_en_o = 1'b1;
          CL_LUI: begin
            rf_wr_en_o   = 1'b1;
            rf_wr_data_o = dec.imm;
          end
          CL_BRANCH: begin
            if (br_taken_i) begin
              pc_d = pc_q + dec.imm;
            end
          end
          CL_JAL: begin
            rf_wr_en_o   = 1'b1;
            rf_wr_data_o = pc_plus4;
            pc_d         = pc_q + dec.imm;
          end
          CL_JALR: begin
            rf_wr_en_o   = 1'b1;
            rf_wr_data_o = pc_plus4;
            pc_d         = alu_result_i & ~word_t'(1);
          end
          // Unknown CSR numbers fall through as no-ops
          CL_CSRR: begin
            if (dec.csr_ok) begin
              rf_wr_en_o   = mngr2proc_val_i;
              rf_wr_data_o = mngr2proc_msg_i;
              state_d      = mngr2proc_val_i ? ST_IDLE : ST_EXEC;
            end
          end
          CL_CSRW: begin
            if (dec.csr_ok && !proc2mngr_rdy_i) begin
              state_d = ST_EXEC;
            end
          end
          CL_LOAD, CL_STORE: state_d = dmem_req_rdy_i ? ST_EWAIT : ST_EXEC;
          default: state_d = ST_IDLE;
        endcase
      end
      ST_EWAIT: begin
        if (dmem_resp_val_i) begin
          state_d      = ST_IDLE;
          rf_wr_en_o   = dec.inst_class == CL_LOAD;
          rf_wr_data_o = dmem_resp_data_i;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // PC moves only when an instruction retires
  assign pc_en = (state_d == ST_IDLE) && (state_q inside {ST_EXEC, ST_EWAIT});

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      pc_q    <= `RV_RESET_PC;
    end else begin
      state_q <= state_d;
      if (pc_en) begin
        pc_q <= pc_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IWAIT && imem_resp_val_i) begin
      ir_q <= imem_resp_data_i;
    end
  end

  //--------------------------------------------------------------------
  // Stream outputs, all decoded from the state
  //--------------------------------------------------------------------
  assign inst_o           = ir_q;
  assign rf_wr_idx_o      = dec.rd;
  assign imem_req_val_o   = state_q == ST_IREQ;
  assign imem_req_addr_o  = pc_q;
  assign imem_resp_rdy_o  = state_q == ST_IWAIT;
  assign dmem_req_val_o   = in_exec && (dec.inst_class inside {CL_LOAD, CL_STORE});
  assign dmem_req_we_o    = dec.inst_class == CL_STORE;
  assign dmem_req_wdata_o = rs2_data_i;
  assign dmem_resp_rdy_o  = state_q == ST_EWAIT;
  assign mngr2proc_rdy_o  = in_exec && dec.inst_class == CL_CSRR && dec.csr_ok;
  assign proc2mngr_val_o  = in_exec && dec.inst_class == CL_CSRW && dec.csr_ok;
  assign proc2mngr_msg_o  = rs1_data_i;

  // Fetch request and its address hold until the memory takes them
  a_imem_req_hold: assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o && !imem_req_rdy_i |=> imem_req_val_o && $stable(imem_req_addr_o));

  a_exec_only: assert property (@(posedge clk) disable iff (reset)
    (dmem_req_val_o || proc2mngr_val_o) |-> state_q == ST_EXEC);

endmodule

// ==== verilog/rv_proc_top.sv ====
//----------------------------------------------------------------------
// Multicycle tinyrv2 subset core, top level
// Four val/rdy streams; a transfer happens when val and rdy are high
// Memory requests are single 32-bit words
//----------------------------------------------------------------------
module rv_proc_top (
  input  logic          clk,
  input  logic          reset,

  // Manager streams
  input  rv_pkg::word_t mngr2proc_msg_i,
  input  logic          mngr2proc_val_i,
  output logic          mngr2proc_rdy_o,
  output rv_pkg::word_t proc2mngr_msg_o,
  output logic          proc2mngr_val_o,
  input  logic          proc2mngr_rdy_i,

  // Instruction memory
  output logic          imem_req_val_o,
  input  logic          imem_req_rdy_i,
  output rv_pkg::word_t imem_req_addr_o,
  input  logic          imem_resp_val_i,
  output logic          imem_resp_rdy_o,
  input  rv_pkg::word_t imem_resp_data_i,

  // Data memory
  output logic          dmem_req_val_o,
  input  logic          dmem_req_rdy_i,
  output logic          dmem_req_we_o,
  output rv_pkg::word_t dmem_req_addr_o,
  output rv_pkg::word_t dmem_req_wdata_o,
  input  logic          dmem_resp_val_i,
  output logic          dmem_resp_rdy_o,
  input  rv_pkg::word_t dmem_resp_data_i
);
  import rv_pkg::*;

  word_t    inst;
  word_t    alu_result;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    rf_wr_data;
  reg_idx_t rf_wr_idx;
  logic     rf_wr_en;
  logic     br_taken;

  rv_dec_if dec_if ();

  rv_decode u_decode (
    .inst_i (inst),
    .dec    (dec_if.decoder)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .reset      (reset),
    .rs1_i      (dec_if.rs1),
    .rs2_i      (dec_if.rs2),
    .wr_idx_i   (rf_wr_idx),
    .wr_en_i    (rf_wr_en),
    .wr_data_i  (rf_wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_alu u_alu (
    .dec        (dec_if.alu),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .result_o   (alu_result),
    .br_taken_o (br_taken)
  );

  // Effective address comes straight from the ALU add
  assign dmem_req_addr_o = alu_result;

  rv_ctrl u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .dec              (dec_if.ctrl),
    .inst_o           (inst),
    .alu_result_i     (alu_result),
    .br_taken_i       (br_taken),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .rf_wr_en_o       (rf_wr_en),
    .rf_wr_idx_o      (rf_wr_idx),
    .rf_wr_data_o     (rf_wr_data),
    .mngr2proc_msg_i  (mngr2proc_msg_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .proc2mngr_msg_o  (proc2mngr_msg_o),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i),
    .imem_req_val_o   (imem_req_val_o),
    .imem_req_rdy_i   (imem_req_rdy_i),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_resp_val_i  (imem_resp_val_i),
    .imem_resp_rdy_o  (imem_resp_rdy_o),
    .imem_resp_data_i (imem_resp_data_i),
    .dmem_req_val_o   (dmem_req_val_o),
    .dmem_req_rdy_i   (dmem_req_rdy_i),
    .dmem_req_we_o    (dmem_req_we_o),
    .dmem_req_wdata_o (dmem_req_wdata_o),
    .dmem_resp_val_i  (dmem_resp_val_i),
    .dmem_resp_rdy_o  (dmem_resp_rdy_o),
    .dmem_resp_data_i (dmem_resp_data_i)
  );

endmodule

// ==== tb/tb_rv_proc.sv ====
//----------------------------------------------------------------------
// Directed testbench for the multicycle core
// Memories and manager streams are modeled here with random delays
// Data memory covers 1 KiB from address 0; programs start at the reset PC
//----------------------------------------------------------------------
`include "rv_cfg.svh"

module tb_rv_proc;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int TOTAL_INSTS = 200;
  localparam int MAX_CPI     = 40;
  localparam int WAIT_LIMIT  = 3000;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  word_t mngr2proc_msg_i = '0;
  logic  mngr2proc_val_i = 1'b0;
  logic  mngr2proc_rdy_o;
  word_t proc2mngr_msg_o;
  logic  proc2mngr_val_o;
  logic  proc2mngr_rdy_i = 1'b0;
  logic  imem_req_val_o;
  logic  imem_req_rdy_i = 1'b0;
  word_t imem_req_addr_o;
  logic  imem_resp_val_i = 1'b0;
  logic  imem_resp_rdy_o;
  word_t imem_resp_data_i = '0;
  logic  dmem_req_val_o;
  logic  dmem_req_rdy_i = 1'b0;
  logic  dmem_req_we_o;
  word_t dmem_req_addr_o;
  word_t dmem_req_wdata_o;
  logic  dmem_resp_val_i = 1'b0;
  logic  dmem_resp_rdy_o;
  word_t dmem_resp_data_i = '0;

  integer seed = 32'he6a4;
  int     errors = 0;
  word_t  imem [256];
  word_t  dmem [256];
  word_t  prog_q[$];
  word_t  exp_q[$];
  word_t  mngr_vals[$];
  word_t  src_q[$];
  word_t  sink_q[$];
  logic   got_first;
  word_t  first_addr;

  rv_proc_top u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(TOTAL_INSTS * MAX_CPI * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

  function automatic logic rnd_bit();
    integer r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic int rnd_below(int n);
    integer r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic word_t dmem_fill(int idx);
    word_t addr;
    addr = idx * 4;
    return {16'hd00d, addr[15:0]};
  endfunction

  //--------------------------------------------------------------------
  // Memory and manager models, sampled at negedge, driven after posedge
  //--------------------------------------------------------------------
  always begin : models
    logic  rst_s, ix_req, ix_resp, dx_req, dx_resp, mx, px, dwe;
    word_t ia, da, dwd, pm;
    logic  ipend, dpend;
    int    idly, ddly;
    word_t irdata, drdata;
    @(negedge clk);
    rst_s   = reset;
    ix_req  = imem_req_val_o && imem_req_rdy_i;
    ia      = imem_req_addr_o;
    ix_resp = imem_resp_val_i && imem_resp_rdy_o;
    dx_req  = dmem_req_val_o && dmem_req_rdy_i;
    da      = dmem_req_addr_o;
    dwe     = dmem_req_we_o;
    dwd     = dmem_req_wdata_o;
    dx_resp = dmem_resp_val_i && dmem_resp_rdy_o;
    mx      = mngr2proc_val_i && mngr2proc_rdy_o;
    px      = proc2mngr_val_o && proc2mngr_rdy_i;
    pm      = proc2mngr_msg_o;
    @(posedge clk);
    #2;
    if (rst_s) begin
      ipend = 1'b0;
      dpend = 1'b0;
      imem_req_rdy_i  = 1'b0;
      imem_resp_val_i = 1'b0;
      dmem_req_rdy_i  = 1'b0;
      dmem_resp_val_i = 1'b0;
      mngr2proc_val_i = 1'b0;
      proc2mngr_rdy_i = 1'b0;
    end else begin
      if (ix_resp) ipend = 1'b0;
      if (ix_req) begin
        ipend  = 1'b1;
        idly   = rnd_below(3);
        irdata = imem[(ia - `RV_RESET_PC) >> 2];
        if (!got_first) begin
          got_first  = 1'b1;
          first_addr = ia;
        end
      end else if (ipend && idly > 0) begin
        idly--;
      end
      if (dx_resp) dpend = 1'b0;
      if (dx_req) begin
        dpend = 1'b1;
        ddly  = rnd_below(3);
        if (dwe) begin
          dmem[da[9:2]] = dwd;
          drdata = '0;
        end else begin
          drdata = dmem[da[9:2]];
        end
      end else if (dpend && ddly > 0) begin
        ddly--;
      end
      if (mx) void'(src_q.pop_front());
      if (px) sink_q.push_back(pm);
      imem_req_rdy_i   = !ipend && rnd_bit();
      imem_resp_val_i  = ipend && idly == 0;
      imem_resp_data_i = irdata;
      dmem_req_rdy_i   = !dpend && rnd_bit();
      dmem_resp_val_i  = dpend && ddly == 0;
      dmem_resp_data_i = drdata;
      // Random back-pressure on the proc2mngr sink
      proc2mngr_rdy_i  = rnd_bit();
      mngr2proc_val_i  = src_q.size() > 0;
      mngr2proc_msg_i  = (src_q.size() > 0) ? src_q[0] : '0;
    end
  end

  //--------------------------------------------------------------------
  // Instruction encoder
  //--------------------------------------------------------------------
  function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic word_t i_type(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic word_t s_type(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_type(int imm, int f3, int rs1, int rs2);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t u_type(int imm20, int rd);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic word_t j_type(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic word_t csr_read(int rd);
    return i_type('hFC0, 0, 2, rd, 'h73);
  endfunction

  function automatic word_t csr_write(int rs1);
    return i_type('h7C0, rs1, 1, 0, 'h73);
  endfunction

  function automatic word_t pc_here();
    return `RV_RESET_PC + prog_q.size() * 4;
  endfunction

  function automatic logic branch_rule(int f3, word_t x, word_t y);
    case (f3)
      0: return x == y;
      1: return x != y;
      4: return $signed(x) < $signed(y);
      5: return $signed(x) >= $signed(y);
      6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic emit(word_t inst);
    prog_q.push_back(inst);
  endtask

  // Instruction that writes x3, then x3 goes to the manager
  task automatic emit_checked(word_t inst, word_t exp);
    emit(inst);
    emit(csr_write(3));
    exp_q.push_back(exp);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_test();
    prog_q.delete();
    exp_q.delete();
    mngr_vals.delete();
  endtask

  //--------------------------------------------------------------------
  // Reset, load, run until all messages arrive, then compare
  //--------------------------------------------------------------------
  task automatic run_program(string name);
    int cycles;
    emit(j_type(0, 0));
    @(posedge clk);
    #2;
    reset = 1'b1;
    @(negedge clk);
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(i, 0, 0, 0, 'h13);
      dmem[i] = dmem_fill(i);
    end
    foreach (prog_q[i]) imem[i] = prog_q[i];
    src_q = mngr_vals;
    sink_q.delete();
    got_first = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    if (imem_req_val_o || imem_resp_rdy_o || dmem_req_val_o || dmem_resp_rdy_o ||
        mngr2proc_rdy_o || proc2mngr_val_o) begin
      $display("%s: a val or rdy output is high in the first cycle after reset", name);
      errors++;
    end
    cycles = 0;
    while (sink_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (sink_q.size() < exp_q.size()) begin
      $display("%s: only %0d of %0d manager messages arrived", name,
               sink_q.size(), exp_q.size());
      errors++;
    end
    foreach (sink_q[i]) begin
      if (i < exp_q.size()) check_word({name, " proc2mngr_msg_o"}, sink_q[i], exp_q[i]);
    end
    if (!got_first) begin
      $display("%s: no instruction fetch was seen", name);
      errors++;
    end else begin
      check_word({name, " imem_req_addr_o"}, first_addr, `RV_RESET_PC);
    end
  endtask

  task automatic reset_and_x0();
    clear_test();
    emit(csr_write(0));
    exp_q.push_back('0);
    run_program("reset_and_x0");
  endtask

  task automatic manager_echo();
    word_t v;
    clear_test();
    for (int i = 0; i < 8; i++) begin
      v = $random(seed);
      mngr_vals.push_back(v);
      exp_q.push_back(v);
      emit(csr_read(1));
      emit(csr_write(1));
    end
    run_program("manager_echo");
  endtask

  task automatic alu_ops();
    word_t a, b;
    a = 32'h8000_0005;
    b = 32'h0000_0003;
    clear_test();
    mngr_vals = '{a, b};
    emit(csr_read(1));
    emit(csr_read(2));
    emit_checked(r_type(0, 2, 1, 0, 3), a + b);
    emit_checked(r_type(32, 2, 1, 0, 3), a - b);
    emit_checked(r_type(0, 2, 1, 7, 3), a & b);
    emit_checked(r_type(0, 2, 1, 6, 3), a | b);
    emit_checked(r_type(0, 2, 1, 4, 3), a ^ b);
    emit_checked(r_type(0, 2, 1, 2, 3), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    emit_checked(r_type(0, 2, 1, 3, 3), (a < b) ? 32'd1 : 32'd0);
    emit_checked(r_type(0, 1, 2, 2, 3), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    emit_checked(r_type(0, 1, 2, 3, 3), (b < a) ? 32'd1 : 32'd0);
    emit_checked(r_type(0, 2, 1, 1, 3), a << 3);
    emit_checked(r_type(0, 2, 1, 5, 3), a >> 3);
    emit_checked(r_type(32, 2, 1, 5, 3), $signed(a) >>> 3);
    emit_checked(i_type(-1, 1, 0, 3, 'h13), a - 1);
    emit_checked(i_type(-16, 1, 7, 3, 'h13), a & 32'hffff_fff0);
    emit_checked(i_type('h123, 1, 6, 3, 'h13), a | 32'h123);
    emit_checked(i_type(-1, 1, 4, 3, 'h13), ~a);
    emit_checked(i_type(0, 1, 2, 3, 'h13), ($signed(a) < 0) ? 32'd1 : 32'd0);
    emit_checked(i_type(-1, 1, 3, 3, 'h13), (a < 32'hffff_ffff) ? 32'd1 : 32'd0);
    emit_checked(i_type(0, 1, 1, 3, 'h13), a);
    emit_checked(i_type(31, 1, 1, 3, 'h13), a << 31);
    emit_checked(i_type(31, 1, 5, 3, 'h13), a >> 31);
    emit_checked(i_type('h400 | 31, 1, 5, 3, 'h13), $signed(a) >>> 31);
    emit_checked(i_type('h400, 1, 5, 3, 'h13), a);
    emit_checked(u_type('hABCDE, 3), 32'hABCD_E000);
    // x0 stays zero after a write
    emit(i_type(5, 1, 0, 0, 'h13));
    emit(csr_write(0));
    exp_q.push_back('0);
    run_program("alu_ops");
  endtask

  task automatic store_load();
    word_t v1, v2;
    v1 = $random(seed);
    v2 = $random(seed);
    clear_test();
    mngr_vals = '{32'h100, v1, v2};
    emit(csr_read(1));
    emit(csr_read(2));
    emit(csr_read(4));
    emit(s_type(0, 2, 1));
    emit(s_type(8, 4, 1));
    emit(s_type(-4, 2, 1));
    emit_checked(i_type(0, 1, 2, 3, 'h03), v1);
    emit_checked(i_type(8, 1, 2, 3, 'h03), v2);
    emit_checked(i_type(-4, 1, 2, 3, 'h03), v1);
    emit_checked(i_type(4, 1, 2, 3, 'h03), dmem_fill('h104 / 4));
    run_program("store_load");
    check_word("dmem[0x100]", dmem['h40], v1);
    check_word("dmem[0x108]", dmem['h42], v2);
    check_word("dmem[0x0fc]", dmem['h3f], v1);
  endtask

  task automatic branches_and_jumps();
    int    f3s [6];
    word_t p;
    int    ra;
    int    rb;
    f3s = '{0, 1, 4, 5, 6, 7};
    clear_test();
    // Count-down loop of five passes
    emit(i_type(5, 0, 0, 1, 'h13));
    emit(i_type(0, 0, 0, 2, 'h13));
    emit(i_type(1, 2, 0, 2, 'h13));
    emit(i_type(-1, 1, 0, 1, 'h13));
    emit(b_type(-8, 1, 1, 0));
    emit(csr_write(2));
    exp_q.push_back(32'd5);
    emit(i_type(-1, 0, 0, 5, 'h13));
    emit(i_type(1, 0, 0, 6, 'h13));
    // Each condition with both operand orders and equal operands, x3 is 0 when taken
    foreach (f3s[i]) begin
      for (int k = 0; k < 3; k++) begin
        ra = (k == 0) ? 5 : 6;
        rb = (k == 1) ? 5 : 6;
        emit(i_type(0, 0, 0, 3, 'h13));
        emit(b_type(8, f3s[i], ra, rb));
        emit(i_type(1, 0, 0, 3, 'h13));
        emit(csr_write(3));
        exp_q.push_back(branch_rule(f3s[i], (ra == 5) ? 32'hffff_ffff : 32'd1,
                                    (rb == 5) ? 32'hffff_ffff : 32'd1) ? 32'd0 : 32'd1);
      end
    end
    emit(i_type(0, 0, 0, 3, 'h13));
    p = pc_here();
    emit(j_type(8, 7));
    emit(i_type(1, 0, 0, 3, 'h13));
    emit(csr_write(7));
    emit(csr_write(3));
    exp_q.push_back(p + 4);
    exp_q.push_back('0);
    // JALR target with bit 0 set, which the core clears
    p = pc_here();
    emit(i_type(int'(p) + 13, 0, 0, 10, 'h13));
    emit(i_type(0, 10, 0, 11, 'h67));
    emit(i_type(1, 0, 0, 3, 'h13));
    emit(csr_write(11));
    emit(csr_write(3));
    exp_q.push_back(p + 8);
    exp_q.push_back('0);
    run_program("branches_and_jumps");
  endtask

  initial begin
    reset_and_x0();
    manager_echo();
    alu_ops();
    store_load();
    branches_and_jumps();
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_dec_if.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_ctrl.sv
verilog/rv_proc_top.sv
tb/tb_rv_proc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_proc \
  -Mdir obj_dir -o sim_rv_proc > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_rv_proc > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
